/* mul_if.sv */
/*
 * multiply pipeline stage interfaces
 * decoder to tile array, tile array to lane sum, lane sum to writeback
 */
`default_nettype none

interface mul_uop_if #(parameter int ROB_W = 6) ();
  logic                            valid;
  logic [ROB_W-1:0]                rob_entry;
  logic [1:0]                      eew;
  logic                            keep_low;
  logic                            is_vsmul;
  logic [1:0]                      vxrm;
  mul_pkg::vreg_t                  src2;
  mul_pkg::vreg_t                  src1;
  logic [mul_pkg::VBYTES-1:0]      src2_sign; // set on top byte of signed elements
  logic [mul_pkg::VBYTES-1:0]      src1_sign;

  modport src (output valid, rob_entry, eew, keep_low, is_vsmul, vxrm,
               src2, src1, src2_sign, src1_sign);
  modport dst (input valid, rob_entry, eew, keep_low, is_vsmul, vxrm,
               src2, src1, src2_sign, src1_sign);
endinterface

interface mul_pp_if #(parameter int ROB_W = 6) ();
  logic                            valid;
  logic [ROB_W-1:0]                rob_entry;
  logic [1:0]                      eew;
  logic                            keep_low;
  logic                            is_vsmul;
  logic [1:0]                      vxrm;
  logic                            dst_signed;
  logic [4*mul_pkg::VBYTES-1:0][16:0] prod; // 17 bit exact byte products

  modport src (output valid, rob_entry, eew, keep_low, is_vsmul, vxrm, dst_signed, prod);
  modport dst (input valid, rob_entry, eew, keep_low, is_vsmul, vxrm, dst_signed, prod);
endinterface

interface mul_full_if #(parameter int ROB_W = 6) ();
  logic                            valid;
  logic [ROB_W-1:0]                rob_entry;
  logic [1:0]                      eew;
  logic                            keep_low;
  logic                            is_vsmul;
  logic [1:0]                      vxrm;
  mul_pkg::full_prod_t             full;

  modport src (output valid, rob_entry, eew, keep_low, is_vsmul, vxrm, full);
  modport dst (input valid, rob_entry, eew, keep_low, is_vsmul, vxrm, full);
endinterface

`default_nettype wire

/* mul_lane_sum.sv */
/*
 * lane sum
 * recombines registered byte products into 16, 32 or 64 bit element products
 */
`default_nettype none

module mul_lane_sum #(
  parameter int ROB_W = 6
) (
  mul_pp_if.dst   pp,
  mul_full_if.src full
);

  logic [mul_pkg::VBYTES-1:0][15:0]   acc8;
  logic [mul_pkg::VBYTES/2-1:0][31:0] acc16;
  logic [mul_pkg::VBYTES/4-1:0][63:0] acc32;

  if ($bits(full.rob_entry) != ROB_W) begin : g_rob_w_check
    $error("lane sum rob tag width does not match ROB_W");
  end

  assign full.valid     = pp.valid;
  assign full.rob_entry = pp.rob_entry;
  assign full.eew       = pp.eew;
  assign full.keep_low  = pp.keep_low;
  assign full.is_vsmul  = pp.is_vsmul;
  assign full.vxrm      = pp.vxrm;

  //////////////////////////////
  // shift and add per width
  //////////////////////////////
  always_comb begin : recombine
    logic [63:0]  term;
    logic [63:0]  shifted;
    int unsigned  e16;
    acc8  = '0;
    acc16 = '0;
    acc32 = '0;
    for (int z = 0; z < 4; z++) begin
      for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
          // cross terms carry a sign only on signed ops
          term = {{47{pp.dst_signed & pp.prod[z*16+y*4+x][16]}}, pp.prod[z*16+y*4+x]};
          if (x == y) begin
            acc8[z*4+x] = term[15:0];
          end
          if (x / 2 == y / 2) begin
            e16        = z * 2 + x / 2;
            shifted    = term << (8 * (x % 2 + y % 2));
            acc16[e16] = acc16[e16] + shifted[31:0];
          end
          acc32[z] = acc32[z] + (term << (8 * (x + y)));
        end
      end
    end
  end

  always_comb begin
    case (pp.eew)
      mul_pkg::EEW32: full.full.p64 = acc32;
      mul_pkg::EEW16: full.full.p32 = acc16;
      default:        full.full.p16 = acc8;  // 8 bit and code 3
    endcase
  end

endmodule

`default_nettype wire

/* mul_pkg.sv */
/*
 * mul_pkg
 * vector sizes, opcode and rounding codes, and the packed lane views
 * shared by the vector integer multiply unit
 */
`default_nettype none

package mul_pkg;

  //////////////////////////////
  // vector geometry
  //////////////////////////////
  localparam int VLEN   = 128;
  localparam int VBYTES = VLEN / 8;

  // element width codes, 3 falls back to 8 bit
  localparam logic [1:0] EEW8  = 2'd0;
  localparam logic [1:0] EEW16 = 2'd1;
  localparam logic [1:0] EEW32 = 2'd2;

  //////////////////////////////
  // opcode fields
  //////////////////////////////
  localparam logic [2:0] OPIVV = 3'b000;
  localparam logic [2:0] OPMVV = 3'b010;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPMVX = 3'b110;

  localparam logic [5:0] F6_VMUL    = 6'b100101;
  localparam logic [5:0] F6_VMULH   = 6'b100111;
  localparam logic [5:0] F6_VMULHU  = 6'b100100;
  localparam logic [5:0] F6_VMULHSU = 6'b100110;
  localparam logic [5:0] F6_VSMUL   = 6'b100111; // only under OPI

  // fixed-point rounding
  localparam logic [1:0] VXRM_RNU = 2'd0; // round to nearest up
  localparam logic [1:0] VXRM_RNE = 2'd1; // round to nearest even
  localparam logic [1:0] VXRM_RDN = 2'd2; // truncate
  localparam logic [1:0] VXRM_ROD = 2'd3; // round to odd

  //////////////////////////////
  // lane views
  //////////////////////////////
  typedef union packed {
    logic [VBYTES-1:0][7:0]    b;
    logic [VBYTES/2-1:0][15:0] h;
    logic [VBYTES/4-1:0][31:0] w;
  } vreg_t;

  // double width element products
  typedef union packed {
    logic [VBYTES-1:0][15:0]   p16;
    logic [VBYTES/2-1:0][31:0] p32;
    logic [VBYTES/4-1:0][63:0] p64;
  } full_prod_t;

endpackage

`default_nettype wire

/* mul_tile_array.sv */
/*
 * byte tile multiplier array
 * 64 signed/unsigned 8x8 tiles in four 4x4 groups, plus the stage-1 register
 */
`default_nettype none

module mul_tile_array #(
  parameter int ROB_W = 6
) (
  input  wire    clk,
  input  wire    rst_n,
  mul_uop_if.dst uop,
  mul_pp_if.src  pp
);

  logic [4*mul_pkg::VBYTES-1:0][16:0] prod_d;

  if ($bits(pp.rob_entry) != ROB_W) begin : g_rob_w_check
    $error("tile array rob tag width does not match ROB_W");
  end

  // tile z*16+y*4+x is src2 byte z*4+x times src1 byte z*4+y
  always_comb begin : tile_mul
    logic signed [8:0]  a9;
    logic signed [8:0]  b9;
    logic signed [17:0] m18;
    for (int z = 0; z < 4; z++) begin
      for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
          a9  = {uop.src2_sign[z*4+x] & uop.src2.b[z*4+x][7], uop.src2.b[z*4+x]};
          b9  = {uop.src1_sign[z*4+y] & uop.src1.b[z*4+y][7], uop.src1.b[z*4+y]};
          m18 = a9 * b9;
          prod_d[z*16+y*4+x] = m18[16:0]; // exact in 17 bits
        end
      end
    end
  end

  //////////////////////////////
  // stage-1 register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pp.valid <= 1'b0;
    end else begin
      pp.valid <= uop.valid;
    end
  end

  always_ff @(posedge clk) begin
    pp.rob_entry  <= uop.rob_entry;
    pp.eew        <= uop.eew;
    pp.keep_low   <= uop.keep_low;
    pp.is_vsmul   <= uop.is_vsmul;
    pp.vxrm       <= uop.vxrm;
    pp.dst_signed <= (|uop.src2_sign) | (|uop.src1_sign); // either source signed
    pp.prod       <= prod_d;
  end

  valid_known: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(pp.valid))
    else $error("stage-1 valid unknown");

endmodule

`default_nettype wire

/* mul_uop_decoder.sv */
/*
 * multiply uop decoder
 * picks the operation from funct3/funct6, builds operand bytes,
 * per-byte signedness and result-mode control
 */
`default_nettype none

module mul_uop_decoder #(
  parameter int ROB_W = 6
) (
  input  wire                 uop_valid,
  input  wire [ROB_W-1:0]     uop_rob_entry,
  input  wire [5:0]           uop_funct6,
  input  wire [2:0]           uop_funct3,
  input  wire [1:0]           uop_vxrm,
  input  wire [1:0]           uop_eew,
  input  wire mul_pkg::vreg_t vs1_data,
  input  wire mul_pkg::vreg_t vs2_data,
  input  wire [31:0]          rs1_data,
  mul_uop_if.src              uop
);

  logic                       src2_signed;
  logic                       src1_signed;
  logic                       is_vx;     // scalar second operand
  logic                       op_ok;     // known funct3
  logic [mul_pkg::VBYTES-1:0] sign_pat;  // top byte of each element
  mul_pkg::vreg_t             scalar;

  assign uop.valid     = uop_valid;
  assign uop.rob_entry = uop_rob_entry;
  assign uop.eew       = uop_eew;
  assign uop.vxrm      = uop_vxrm;

  //////////////////////////////
  // operation select
  //////////////////////////////
  always_comb begin
    is_vx        = uop_funct3[2];
    op_ok        = 1'b1;
    src2_signed  = 1'b1;
    src1_signed  = 1'b1;
    uop.keep_low = 1'b1;
    uop.is_vsmul = 1'b0;
    case (uop_funct3)
      mul_pkg::OPMVV, mul_pkg::OPMVX: begin
        case (uop_funct6)
          mul_pkg::F6_VMULH: uop.keep_low = 1'b0;
          mul_pkg::F6_VMULHU: begin
            uop.keep_low = 1'b0;
            src2_signed  = 1'b0;
            src1_signed  = 1'b0;
          end
          mul_pkg::F6_VMULHSU: begin
            uop.keep_low = 1'b0;
            src1_signed  = 1'b0;
          end
          default: ; // vmul and anything unknown
        endcase
      end
      mul_pkg::OPIVV, mul_pkg::OPIVX: begin
        uop.keep_low = 1'b0;   // every OPI funct6 runs as vsmul
        uop.is_vsmul = 1'b1;
      end
      default: begin
        op_ok       = 1'b0;    // zero operands give a zero result
        src2_signed = 1'b0;
        src1_signed = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // operands and sign bytes
  //////////////////////////////
  always_comb begin
    case (uop_eew)
      mul_pkg::EEW16: begin
        sign_pat = {8{2'b10}};
        scalar.h = {8{rs1_data[15:0]}};
      end
      mul_pkg::EEW32: begin
        sign_pat = {4{4'b1000}};
        scalar.w = {4{rs1_data}};
      end
      default: begin
        sign_pat = {16{1'b1}};
        scalar.b = {16{rs1_data[7:0]}};
      end
    endcase
    uop.src2      = op_ok ? vs2_data : '0;
    uop.src1      = !op_ok ? '0 : (is_vx ? scalar : vs1_data);
    uop.src2_sign = src2_signed ? sign_pat : '0;
    uop.src1_sign = src1_signed ? sign_pat : '0;
  end

  // lane layout depends on a known width
  always_comb begin
    eew_known: assert final (!uop_valid || !$isunknown(uop_eew))
      else $error("uop_eew unknown on a valid uop");
  end

endmodule

`default_nettype wire

/* mul_writeback.sv */
/*
 * multiply writeback
 * high/low half select, vsmul rounding and saturation, output register
 */
`default_nettype none

module mul_writeback #(
  parameter int ROB_W = 6
) (
  input  wire            clk,
  input  wire            rst_n,
  mul_full_if.dst        full,
  output logic           res_valid,
  output logic [ROB_W-1:0] res_rob_entry,
  output mul_pkg::vreg_t res_data,
  output logic           res_vxsat
);

  mul_pkg::vreg_t nxt_data;
  logic           sat_any;

  // one element of width w from its 2w product, {sat, value}
  function automatic logic [32:0] lane_result(input logic [63:0] p,
                                              input int unsigned w,
                                              input logic keep_low,
                                              input logic vsmul,
                                              input logic [1:0] vxrm);
    logic [63:0] shr;
    logic [63:0] hi;
    logic [31:0] wmask;
    logic [31:0] val;
    logic        lsb;
    logic        rbit;
    logic        sticky;
    logic        incr;
    logic        sat;
    wmask  = 32'((64'd1 << w) - 64'd1);
    shr    = p >> (w - 1);       // vsmul keeps bits 2w-2 .. w-1
    hi     = p >> w;
    lsb    = p[w-1];
    rbit   = p[w-2];
    sticky = |(p & ((64'd1 << (w - 2)) - 64'd1));
    case (vxrm)
      mul_pkg::VXRM_RNU: incr = rbit;
      mul_pkg::VXRM_RNE: incr = rbit & (sticky | lsb);
      mul_pkg::VXRM_RDN: incr = 1'b0;
      default:           incr = ~lsb & (rbit | sticky);
    endcase
    sat = vsmul && ({p[2*w-1], p[2*w-2]} == 2'b01); // only min * min
    if (!vsmul) begin
      val = keep_low ? (p[31:0] & wmask) : (hi[31:0] & wmask);
    end else if (sat) begin
      val = wmask >> 1;          // largest positive
    end else begin
      val = (shr[31:0] + {31'b0, incr}) & wmask;
    end
    return {sat, val};
  endfunction

  //////////////////////////////
  // per lane results
  //////////////////////////////
  always_comb begin
    logic [32:0] r;
    sat_any = 1'b0;
    case (full.eew)
      mul_pkg::EEW32: begin
        for (int i = 0; i < mul_pkg::VBYTES / 4; i++) begin
          r = lane_result(full.full.p64[i], 32, full.keep_low, full.is_vsmul, full.vxrm);
          nxt_data.w[i] = r[31:0];
          sat_any       = sat_any | r[32];
        end
      end
      mul_pkg::EEW16: begin
        for (int i = 0; i < mul_pkg::VBYTES / 2; i++) begin
          r = lane_result({32'b0, full.full.p32[i]}, 16, full.keep_low, full.is_vsmul,
                          full.vxrm);
          nxt_data.h[i] = r[15:0];
          sat_any       = sat_any | r[32];
        end
      end
      default: begin
        for (int i = 0; i < mul_pkg::VBYTES; i++) begin
          r = lane_result({48'b0, full.full.p16[i]}, 8, full.keep_low, full.is_vsmul,
                          full.vxrm);
          nxt_data.b[i] = r[7:0];
          sat_any       = sat_any | r[32];
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      res_vxsat <= 1'b0;
    end else begin
      res_valid <= full.valid;
      res_vxsat <= full.valid & sat_any;
    end
  end

  always_ff @(posedge clk) begin
    res_rob_entry <= full.rob_entry;
    res_data      <= nxt_data;
  end

  vxsat_only_vsmul: assert property (@(posedge clk) disable iff (!rst_n)
    full.valid && !full.is_vsmul |=> !res_vxsat)
    else $error("vxsat raised on a non-vsmul op");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the multiply unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_vmul_unit -f src.f -o sim_vmul_unit
./obj_dir/sim_vmul_unit | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* src.f */
mul_pkg.sv
mul_if.sv
mul_uop_decoder.sv
mul_tile_array.sv
mul_lane_sum.sv
mul_writeback.sv
vmul_unit.sv
tb_mul_checker.sv
tb_vmul_unit.sv

/* tb_mul_checker.sv */
/*
 * multiply unit checker
 * predicts each result from the uop, queues it and compares the DUT
 * outputs two cycles later
 */
`default_nettype none

module tb_mul_checker #(
  parameter int ROB_W = 6
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              uop_valid,
  input  wire [ROB_W-1:0]  uop_rob_entry,
  input  wire [5:0]        uop_funct6,
  input  wire [2:0]        uop_funct3,
  input  wire [1:0]        uop_vxrm,
  input  wire [1:0]        uop_eew,
  input  wire [127:0]      vs1_data,
  input  wire [127:0]      vs2_data,
  input  wire [31:0]       rs1_data,
  input  wire              res_valid,
  input  wire [ROB_W-1:0]  res_rob_entry,
  input  wire [127:0]      res_data,
  input  wire              res_vxsat,
  output int               issued,
  output int               retired,
  output int               mismatch_errors,
  output int               other_errors
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [127:0]     data_q[$];
  logic             sat_q[$];
  logic [ROB_W-1:0] rob_q[$];
  longint           due_q[$];  // cycle the result must show up
  longint           cycle;
  logic [128:0]     expected;

  // {vxsat, data} for one uop
  function automatic logic [128:0] ref_result(input logic [5:0] f6, input logic [2:0] f3,
                                              input logic [1:0] vxrm, input logic [1:0] eew,
                                              input logic [127:0] vs1, input logic [127:0] vs2,
                                              input logic [31:0] rs1);
    int                 sew;
    int                 d;
    logic               s2;
    logic               s1;
    logic               hi;
    logic               sm;
    logic               inc;
    logic               sat;
    logic [65:0]        mask;
    logic [65:0]        ea;
    logic [65:0]        eb;
    logic [65:0]        pu;
    logic signed [65:0] p;
    logic signed [65:0] v;
    logic signed [65:0] lim;
    logic [127:0]       data;
    sew  = (eew == mul_pkg::EEW16) ? 16 : ((eew == mul_pkg::EEW32) ? 32 : 8);
    d    = sew - 1;
    mask = (66'd1 << sew) - 66'd1;
    lim  = (66'd1 << d) - 66'd1;       // largest positive element
    data = '0;
    sat  = 1'b0;
    s2   = 1'b1;
    s1   = 1'b1;
    hi   = 1'b0;
    sm   = 1'b0;
    case (f3)
      mul_pkg::OPMVV, mul_pkg::OPMVX: begin
        if (f6 == mul_pkg::F6_VMULH) begin
          hi = 1'b1;
        end else if (f6 == mul_pkg::F6_VMULHU) begin
          hi = 1'b1;
          s2 = 1'b0;
          s1 = 1'b0;
        end else if (f6 == mul_pkg::F6_VMULHSU) begin
          hi = 1'b1;
          s1 = 1'b0;
        end
      end
      mul_pkg::OPIVV, mul_pkg::OPIVX: sm = 1'b1;
      default: return 129'd0;           // unused funct3
    endcase
    for (int i = 0; i < 128 / sew; i++) begin
      ea = 66'(vs2 >> (i * sew)) & mask;
      eb = f3[2] ? (66'(rs1) & mask) : (66'(vs1 >> (i * sew)) & mask);
      if (s2 && ea[sew-1]) ea = ea | ~mask;
      if (s1 && eb[sew-1]) eb = eb | ~mask;
      p  = $signed(ea) * $signed(eb);
      pu = p;
      if (sm) begin
        case (vxrm)
          mul_pkg::VXRM_RNU: inc = pu[d-1];
          mul_pkg::VXRM_RNE: inc = pu[d-1] & (((pu & ((66'd1 << (d - 1)) - 66'd1)) != 0) | pu[d]);
          mul_pkg::VXRM_RDN: inc = 1'b0;
          default:           inc = ~pu[d] & ((pu & ((66'd1 << d) - 66'd1)) != 0);
        endcase
        v = p >>> d;
        v = v + 66'(inc);
        if (v > lim) begin
          v   = lim;                    // clip
          sat = 1'b1;
        end
      end else if (hi) begin
        v = p >>> sew;
      end else begin
        v = p;
      end
      data = data | (128'(v & mask) << (i * sew));
    end
    return {sat, data};
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] got);
    mismatch_errors++;
    $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic drop_front();
    void'(data_q.pop_front());
    void'(sat_q.pop_front());
    void'(rob_q.pop_front());
    void'(due_q.pop_front());
    retired++;
  endtask

  //////////////////////////////
  // capture on rise, compare on fall
  //////////////////////////////
  always begin
    @(posedge clk);
    cycle++;
    if (rst_n === 1'b1 && uop_valid === 1'b1) begin
      expected = ref_result(uop_funct6, uop_funct3, uop_vxrm, uop_eew,
                            vs1_data, vs2_data, rs1_data);
      data_q.push_back(expected[127:0]);
      sat_q.push_back(expected[128]);
      rob_q.push_back(uop_rob_entry);
      due_q.push_back(cycle + 1);       // writeback registers one edge after capture
      issued++;
    end
    @(negedge clk);
    if (rst_n !== 1'b1) begin
      if (res_valid !== 1'b0 || res_vxsat !== 1'b0) begin
        other_errors++;
        $display("%0t: res_valid or res_vxsat not low during reset", $time);
      end
    end else if (res_valid === 1'b1) begin
      if (due_q.size() == 0) begin
        other_errors++;
        $display("%0t: res_valid high with no uop in flight", $time);
      end else begin
        if (due_q[0] != cycle) begin
          other_errors++;
          $display("%0t: result for rob entry %0d came in cycle %0d, due in cycle %0d",
                   $time, rob_q[0], cycle, due_q[0]);
        end
        if (res_rob_entry !== rob_q[0])
          report_mismatch("res_rob_entry", 128'(rob_q[0]), 128'(res_rob_entry));
        if (res_data !== data_q[0]) report_mismatch("res_data", data_q[0], res_data);
        if (res_vxsat !== sat_q[0]) report_mismatch("res_vxsat", 128'(sat_q[0]), 128'(res_vxsat));
        drop_front();
      end
    end else begin
      if (res_valid !== 1'b0) begin
        other_errors++;
        $display("%0t: res_valid is unknown", $time);
      end
      if (res_vxsat !== 1'b0) report_mismatch("res_vxsat", 128'd0, 128'(res_vxsat));
      if (due_q.size() != 0 && due_q[0] <= cycle) begin
        other_errors++;
        $display("%0t: no result for rob entry %0d in its due cycle",
                 $time, rob_q[0]);
        drop_front();
      end
    end
  end

endmodule

`default_nettype wire

/* tb_vmul_unit.sv */
/*
 * vector multiply unit testbench
 * clock, reset, directed and random uops, DUT and checker instances
 */
`default_nettype none

module tb_vmul_unit;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROB_W = 6;
  localparam logic [5:0] MUL_OPS [4] = '{mul_pkg::F6_VMUL, mul_pkg::F6_VMULH,
                                         mul_pkg::F6_VMULHU, mul_pkg::F6_VMULHSU};

  logic             clk;
  logic             rst_n;
  logic             uop_valid;
  logic [ROB_W-1:0] uop_rob_entry;
  logic [5:0]       uop_funct6;
  logic [2:0]       uop_funct3;
  logic [1:0]       uop_vxrm;
  logic [1:0]       uop_eew;
  logic [127:0]     vs1_data;
  logic [127:0]     vs2_data;
  logic [31:0]      rs1_data;
  logic             res_valid;
  logic [ROB_W-1:0] res_rob_entry;
  logic [127:0]     res_data;
  logic             res_vxsat;
  int               issued;
  int               retired;
  int               mismatch_errors;
  int               other_errors;
  integer           seed;
  int               wait_cycles;
  logic [31:0]      pick;
  logic [127:0]     mv;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 40 ns period
  end

  vmul_unit #(.ROB_W(ROB_W)) i_dut (.*);

  tb_mul_checker #(.ROB_W(ROB_W)) u_checker (.*);

  function automatic logic [127:0] rand_vec();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // most negative element in every lane
  function automatic logic [127:0] min_vec(input logic [1:0] eew);
    case (eew)
      mul_pkg::EEW16: return {8{16'h8000}};
      mul_pkg::EEW32: return {4{32'h8000_0000}};
      default:        return {16{8'h80}};
    endcase
  endfunction

  // called on a falling edge, holds the uop for one cycle
  task automatic send_uop(input logic [5:0] f6, input logic [2:0] f3, input logic [1:0] vxrm,
                          input logic [1:0] eew, input logic [127:0] vs1,
                          input logic [127:0] vs2, input logic [31:0] rs1);
    uop_valid  = 1'b1;
    uop_funct6 = f6;
    uop_funct3 = f3;
    uop_vxrm   = vxrm;
    uop_eew    = eew;
    vs1_data   = vs1;
    vs2_data   = vs2;
    rs1_data   = rs1;
    @(negedge clk);
    uop_rob_entry = uop_rob_entry + 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    uop_valid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  initial begin
    seed          = 32'hb3f3_f15c;
    rst_n         = 1'b0;
    uop_valid     = 1'b0;
    uop_rob_entry = '0;
    uop_funct6    = '0;
    uop_funct3    = '0;
    uop_vxrm      = '0;
    uop_eew       = '0;
    vs1_data      = '0;
    vs2_data      = '0;
    rs1_data      = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    idle_cycles(2);

    //////////////////////////////
    // plain multiplies, vv and vx
    //////////////////////////////
    for (int e = 0; e < 3; e++) begin
      for (int k = 0; k < 4; k++) begin
        repeat (3) send_uop(MUL_OPS[k], mul_pkg::OPMVV, 2'($random(seed)), 2'(e),
                            rand_vec(), rand_vec(), 32'($random(seed)));
        send_uop(MUL_OPS[k], mul_pkg::OPMVV, 2'd0, 2'(e), {4{32'h8000_ff7f}},
                 {4{32'hfffe_8081}}, 32'd0);       // negative lanes
        repeat (3) send_uop(MUL_OPS[k], mul_pkg::OPMVX, 2'($random(seed)), 2'(e),
                            rand_vec(), rand_vec(), 32'($random(seed)));
      end
    end

    // vsmul per rounding mode, with min * min lanes
    for (int e = 0; e < 3; e++) begin
      mv = min_vec(2'(e));
      for (int r = 0; r < 4; r++) begin
        send_uop(mul_pkg::F6_VSMUL, mul_pkg::OPIVV, 2'(r), 2'(e), rand_vec(), rand_vec(), 32'd0);
        send_uop(mul_pkg::F6_VSMUL, mul_pkg::OPIVX, 2'(r), 2'(e), rand_vec(), rand_vec(),
                 32'($random(seed)));
        send_uop(mul_pkg::F6_VSMUL, mul_pkg::OPIVV, 2'(r), 2'(e), mv, mv, 32'd0);
        send_uop(mul_pkg::F6_VSMUL, mul_pkg::OPIVX, 2'(r), 2'(e), rand_vec(), mv, mv[31:0]);
      end
    end

    // random mix with gaps, odd funct6 and eew code 3
    repeat (60) begin
      pick = $random(seed);
      send_uop({3'b100, pick[2:0]}, pick[5:3], pick[7:6], pick[9:8], rand_vec(), rand_vec(),
               32'($random(seed)));
      if (pick[12:10] == 3'd0) idle_cycles(1 + int'(pick[14:13]));
    end

    for (int f = 1; f < 8; f += 2) begin   // unused funct3 codes
      send_uop(mul_pkg::F6_VMUL, 3'(f), 2'd0, 2'd0, rand_vec(), rand_vec(), 32'($random(seed)));
    end
    idle_cycles(1);

    wait_cycles = 0;
    while (issued != retired && wait_cycles < 20) begin
      @(negedge clk);
      wait_cycles++;
    end
    repeat (4) @(negedge clk);             // res_valid must stay low

    $display("checked %0d of %0d uops: %0d mismatches, %0d other errors",
             retired, issued, mismatch_errors, other_errors);
    if (issued != retired) begin
      $display("timeout: %0d results never came back", issued - retired);
      $display("ERRORS FOUND");
    end else if (mismatch_errors + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vmul_unit.sv */
/*
 * vector integer multiply unit
 * 128-bit datapath, one uop per cycle, result two cycles later
 */
`default_nettype none

module vmul_unit #(
  parameter int ROB_W = 6
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        uop_valid,
  input  wire [ROB_W-1:0]            uop_rob_entry,
  input  wire [5:0]                  uop_funct6,
  input  wire [2:0]                  uop_funct3,
  input  wire [1:0]                  uop_vxrm,
  input  wire [1:0]                  uop_eew,
  input  wire [mul_pkg::VLEN-1:0]    vs1_data,
  input  wire [mul_pkg::VLEN-1:0]    vs2_data,
  input  wire [31:0]                 rs1_data,
  output logic                       res_valid,
  output logic [ROB_W-1:0]           res_rob_entry,
  output logic [mul_pkg::VLEN-1:0]   res_data,
  output logic                       res_vxsat
);

  //////////////////////////////
  // stage links
  //////////////////////////////
  mul_uop_if  #(.ROB_W(ROB_W)) uop_if  ();
  mul_pp_if   #(.ROB_W(ROB_W)) pp_if   ();
  mul_full_if #(.ROB_W(ROB_W)) full_if ();

  mul_uop_decoder #(.ROB_W(ROB_W)) u_decoder (
    .uop_valid     (uop_valid),
    .uop_rob_entry (uop_rob_entry),
    .uop_funct6    (uop_funct6),
    .uop_funct3    (uop_funct3),
    .uop_vxrm      (uop_vxrm),
    .uop_eew       (uop_eew),
    .vs1_data      (vs1_data),
    .vs2_data      (vs2_data),
    .rs1_data      (rs1_data),
    .uop           (uop_if.src)
  );

  mul_tile_array #(.ROB_W(ROB_W)) u_tile_array ( // stage 1 register
    .clk   (clk),
    .rst_n (rst_n),
    .uop   (uop_if.dst),
    .pp    (pp_if.src)
  );

  mul_lane_sum #(.ROB_W(ROB_W)) u_lane_sum (
    .pp   (pp_if.dst),
    .full (full_if.src)
  );

  mul_writeback #(.ROB_W(ROB_W)) u_writeback ( // stage 2 register
    .clk           (clk),
    .rst_n         (rst_n),
    .full          (full_if.dst),
    .res_valid     (res_valid),
    .res_rob_entry (res_rob_entry),
    .res_data      (res_data),
    .res_vxsat     (res_vxsat)
  );

endmodule

`default_nettype wire
